//--- filelist.f
src/soc_pkg.sv
src/csr_regs.sv
src/soc_csr.sv
src/soc_timer.sv
src/soc_gpio.sv
src/soc_periph_top.sv
test/tb_checker.sv
test/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
   --top-module tb_top -f filelist.f -o tb_sim

sim_out=$(./obj_dir/tb_sim)
echo "$sim_out"

if grep -qx "Regression passed" <<< "$sim_out"; then
   exit 0
fi
exit 1

//--- test/tb_top.sv
`timescale 1ns/100ps

module tb_top;
   import soc_pkg::*;

   // Bus operations in the whole run and the worst cycle cost of each
   localparam int NUM_OPS    = 500;
   localparam int CYC_PER_OP = 2;
   localparam int MARGIN_CYC = 300;
   localparam int CLK_PERIOD = 4;
   localparam int TIMEOUT_NS = (NUM_OPS * CYC_PER_OP + MARGIN_CYC) * CLK_PERIOD;

   logic        bus;
   logic        rst_n;
   bus_req_t    bus_req;
   logic [31:0] rdat;
   logic        rd_vld;
   logic [7:0]  gpio_in;
   logic [7:0]  gpio_out;
   logic        irq;
   int          err_cnt;
   int          rd_cnt;
   integer      seed;

   initial begin
      bus = 1'b0;
      forever #(CLK_PERIOD / 2) bus = ~bus;
   end

   soc_periph_top soc_periph_top_inst (
      .bus      (bus),
      .rst_n    (rst_n),
      .bus_req  (bus_req),
      .rdat     (rdat),
      .rd_vld   (rd_vld),
      .gpio_in  (gpio_in),
      .gpio_out (gpio_out),
      .irq      (irq)
   );

   // Reference model and all comparisons
   tb_checker tb_checker_inst (
      .bus      (bus),
      .rst_n    (rst_n),
      .bus_req  (bus_req),
      .rdat     (rdat),
      .rd_vld   (rd_vld),
      .gpio_out (gpio_out),
      .gpio_in  (gpio_in),
      .irq      (irq),
      .err_cnt  (err_cnt),
      .rd_cnt   (rd_cnt)
   );

   // ==================================================
   // Bus tasks
   // ==================================================

   // One request per cycle where zero strobes mean a read
   task automatic drive_req(input logic [4:0] idx, input logic [3:0] we,
                            input logic [31:0] data);
      @(posedge bus);
      bus_req <= '{vld: 1'b1, we: we, addr: {1'b0, idx, 2'b00}, wdat: data};
   endtask

   task automatic bus_read(input logic [4:0] idx);
      drive_req(idx, 4'h0, 32'd0);
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge bus);
         bus_req <= '0;
      end
   endtask

   // New pin value followed by the synchronizer delay
   task automatic set_pins(input logic [7:0] val);
      @(posedge bus);
      bus_req <= '0;
      gpio_in <= val;
      idle(8);
   endtask

   task automatic random_op();
      logic [31:0] r;
      logic [31:0] d;
      logic [4:0]  idx;
      r = $random(seed);
      d = $random(seed);
      case (r[2:0])
         3'd0, 3'd4: idx = {2'b00, REG_SCRATCH};
         3'd1: begin
            idx = {2'b00, REG_CTRL};
            // Timer stays off during random traffic
            d[CTRL_TIMER_EN] = 1'b0;
         end
         3'd2: idx = {2'b00, REG_TIMER_CMP};
         3'd3: idx = {2'b00, REG_GPIO_OUT};
         3'd5: idx = {2'b00, REG_ID};
         3'd6: idx = {2'b00, REG_TIMER_CNT};
         default: idx = {2'b00, REG_GPIO_IN};
      endcase
      if (r[3]) drive_req(idx, r[7:4], d);
      else bus_read(idx);
      // Mostly back to back with an idle gap now and then
      if (r[9:8] == 2'b00) idle(1);
   endtask

   // ==================================================
   // Test sequence
   // ==================================================

   initial begin
      seed    = 63;
      rst_n   = 1'b0;
      bus_req = '0;
      gpio_in = '0;
      repeat (3) @(posedge bus);
      rst_n <= 1'b1;

      // Reset values of mapped and unmapped indices
      for (int i = 0; i < 12; i++) bus_read(5'(i));
      bus_read(5'd31);

      // Random masked traffic
      for (int n = 0; n < 200; n++) random_op();
      drive_req({2'b00, REG_CTRL}, 4'hF, 32'd0);
      for (int i = 0; i < 8; i++) bus_read(5'(i));

      // Input pins read back through GPIO_IN
      for (int n = 0; n < 4; n++) begin
         set_pins(8'($random(seed)));
         bus_read({2'b00, REG_GPIO_IN});
      end
      drive_req({2'b00, REG_STATUS}, 4'h1, 32'h3);
      idle(2);
      bus_read({2'b00, REG_STATUS});

      // GPIO edge with its interrupt enabled
      drive_req({2'b00, REG_CTRL}, 4'h1, 32'h4);
      set_pins(8'h00);
      drive_req({2'b00, REG_STATUS}, 4'h1, 32'h3);
      set_pins(8'h10);
      bus_read({2'b00, REG_STATUS});
      drive_req({2'b00, REG_STATUS}, 4'h1, 32'h0);
      idle(2);
      bus_read({2'b00, REG_STATUS});
      drive_req({2'b00, REG_STATUS}, 4'h1, 32'h2);
      idle(4);
      bus_read({2'b00, REG_STATUS});
      idle(4);

      // Timer at CMP 3 and prescale 1 with irq enabled
      drive_req({2'b00, REG_TIMER_CMP}, 4'hF, 32'd3);
      drive_req({2'b00, REG_CTRL}, 4'h3, 32'h0000_0103);
      for (int n = 0; n < 24; n++) bus_read({2'b00, REG_TIMER_CNT});
      drive_req({2'b00, REG_CTRL}, 4'h3, 32'h0000_0102);
      idle(6);
      bus_read({2'b00, REG_STATUS});
      bus_read({2'b00, REG_TIMER_CNT});
      idle(5);
      bus_read({2'b00, REG_TIMER_CNT});
      drive_req({2'b00, REG_STATUS}, 4'h1, 32'h1);
      idle(4);
      bus_read({2'b00, REG_STATUS});
      idle(6);

      // Checker has finished the last rising edge by now
      @(negedge bus);
      $display("Errors: %0d, reads checked: %0d", err_cnt, rd_cnt);
      if (err_cnt == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // Ends a stuck run
   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: test sequence did not complete within %0d ns", TIMEOUT_NS);
      $display("Regression failed");
      $finish;
   end

endmodule: tb_top

//--- test/tb_checker.sv
`timescale 1ns/100ps

module tb_checker (
   input  logic              bus,
   input  logic              rst_n,
   input  soc_pkg::bus_req_t bus_req,
   input  logic [31:0]       rdat,
   input  logic              rd_vld,
   input  logic [7:0]        gpio_out,
   input  logic [7:0]        gpio_in,
   input  logic              irq,
   output int                err_cnt,
   output int                rd_cnt
);
   import soc_pkg::*;

   // Model of the writable registers
   logic [31:0] scratch_m;
   logic [31:0] ctrl_m;
   logic [31:0] cmp_m;
   logic [7:0]  gpo_m;
   logic [1:0]  stat_m;
   // Pins trail the GPIO_OUT model by two samples
   logic [7:0]  gpo_d1;
   logic [7:0]  gpo_d2;
   // Last value seen on the input pins
   logic [7:0]  gin_last;
   // Cycles until timer status, GPIO status or irq have settled
   int          wait_t;
   int          wait_g;
   int          wait_irq;
   int          run_cyc;
   // Expected interrupt line from the model
   logic        irq_exp;
   // Count of a stopped timer that must not move
   logic [31:0] cnt_hold;
   logic        hold_vld;
   // Read in flight
   logic        pend_vld;
   logic [4:0]  pend_idx;
   logic [31:0] pend_exp;
   logic [31:0] pend_care;
   logic        pend_run;
   logic        pend_stop;
   logic [4:0]  idx;

   // ==================================================
   // Reference model
   // ==================================================

   // Byte lanes with a strobe take the new data
   function automatic logic [31:0] apply_strobes(input logic [31:0] old_v,
                                                 input logic [31:0] new_v,
                                                 input logic [3:0]  we);
      logic [31:0] res;
      res = old_v;
      for (int b = 0; b < 4; b++) begin
         if (we[b]) res[8*b +: 8] = new_v[8*b +: 8];
      end
      return res;
   endfunction

   // Expected read data per word index
   function automatic logic [31:0] ref_read(input logic [4:0] i);
      if (i[4:3] != 2'b00) return 32'd0;
      case (i[2:0])
         REG_ID:        return SOC_ID;
         REG_SCRATCH:   return scratch_m;
         REG_CTRL:      return ctrl_m;
         REG_TIMER_CMP: return cmp_m;
         REG_STATUS:    return {30'd0, stat_m};
         REG_GPIO_OUT:  return {24'd0, gpo_m};
         REG_GPIO_IN:   return {24'd0, gin_last};
         default:       return 32'd0;
      endcase
   endfunction

   // Bits that are settled and worth comparing
   function automatic logic [31:0] ref_care(input logic [4:0] i);
      if (i == {2'b00, REG_TIMER_CNT}) return 32'd0;
      if (i == {2'b00, REG_GPIO_IN} && wait_g != 0) return 32'd0;
      if (i == {2'b00, REG_STATUS}) return {30'd0, wait_g == 0, wait_t == 0};
      return 32'hFFFF_FFFF;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
      err_cnt++;
      $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp_v, act_v);
   endtask

   // ==================================================
   // Compare process
   // ==================================================

   always @(posedge bus) begin
      if (!rst_n) begin
         scratch_m = '0;
         ctrl_m    = '0;
         cmp_m     = '0;
         gpo_m     = '0;
         stat_m    = '0;
         gpo_d1    = '0;
         gpo_d2    = '0;
         gin_last  = '0;
         wait_t    = 0;
         wait_g    = 0;
         wait_irq  = 0;
         run_cyc   = 0;
         cnt_hold  = '0;
         hold_vld  = 1'b1;
         pend_vld  = 1'b0;
         err_cnt   = 0;
         rd_cnt    = 0;
      end else begin
         // Response to the request of the last sample
         if (rd_vld !== pend_vld) begin
            report_mismatch("rd_vld", 32'(pend_vld), 32'(rd_vld));
         end else if (pend_vld) begin
            rd_cnt++;
            if ((rdat & pend_care) !== (pend_exp & pend_care))
               report_mismatch($sformatf("rdat[%0d]", pend_idx), pend_exp, rdat);
            // Running count stays within the compare value
            if (pend_run && rdat > cmp_m)
               report_mismatch("timer_cnt", cmp_m, rdat);
            if (pend_stop) begin
               if (hold_vld && rdat !== cnt_hold)
                  report_mismatch("timer_cnt", cnt_hold, rdat);
               cnt_hold = rdat;
               hold_vld = 1'b1;
            end
         end

         if (gpio_out !== gpo_d2) report_mismatch("gpio_out", 32'(gpo_d2), 32'(gpio_out));
         gpo_d2 = gpo_d1;

         // Enabled sticky bits drive irq once nothing is in flight
         irq_exp = (stat_m[STAT_TIMER] & ctrl_m[CTRL_TIMER_IRQ_EN]) |
                   (stat_m[STAT_GPIO] & ctrl_m[CTRL_GPIO_IRQ_EN]);
         if (wait_t == 0 && wait_g == 0 && wait_irq == 0 && irq !== irq_exp)
            report_mismatch("irq", 32'(irq_exp), 32'(irq));

         if (wait_t > 0) wait_t--;
         if (wait_g > 0) wait_g--;
         if (wait_irq > 0) wait_irq--;

         // Timer sets its status bit once enough ticks have passed
         if (ctrl_m[CTRL_TIMER_EN]) begin
            run_cyc++;
            wait_t   = 4;
            hold_vld = 1'b0;
            if (run_cyc >= (int'(cmp_m) + 1) * (int'(ctrl_m[15:8]) + 1) + 4)
               stat_m[STAT_TIMER] = 1'b1;
         end else begin
            run_cyc = 0;
         end

         // A rising bit on the input pins is a GPIO event
         if (gpio_in !== gin_last) begin
            if (|(gpio_in & ~gin_last)) stat_m[STAT_GPIO] = 1'b1;
            gin_last = gpio_in;
            wait_g   = 6;
         end

         // New request
         pend_vld = 1'b0;
         idx      = bus_req.addr[6:2];
         if (bus_req.vld && |bus_req.we) begin
            if (idx[4:3] == 2'b00) begin
               case (idx[2:0])
                  REG_SCRATCH:   scratch_m = apply_strobes(scratch_m, bus_req.wdat, bus_req.we);
                  REG_CTRL: begin
                     // CTRL keeps bits 2:0 and the prescale byte 15:8
                     ctrl_m   = apply_strobes(ctrl_m, bus_req.wdat, bus_req.we) &
                                {16'd0, 8'hFF, 5'd0, 3'b111};
                     wait_irq = 2;
                  end
                  REG_TIMER_CMP: cmp_m = apply_strobes(cmp_m, bus_req.wdat, bus_req.we);
                  REG_STATUS: begin
                     stat_m   = stat_m & ~(bus_req.wdat[1:0] & {2{bus_req.we[0]}});
                     wait_irq = 2;
                  end
                  REG_GPIO_OUT: begin
                     if (bus_req.we[0]) gpo_m = bus_req.wdat[7:0];
                  end
                  default: ;
               endcase
            end
         end else if (bus_req.vld) begin
            pend_vld  = 1'b1;
            pend_idx  = idx;
            pend_exp  = ref_read(idx);
            pend_care = ref_care(idx);
            pend_run  = (idx == {2'b00, REG_TIMER_CNT}) && ctrl_m[CTRL_TIMER_EN];
            pend_stop = (idx == {2'b00, REG_TIMER_CNT}) && !ctrl_m[CTRL_TIMER_EN] &&
                        wait_t == 0;
         end
         gpo_d1 = gpo_m;
      end
   end

endmodule: tb_checker

//--- src/soc_periph_top.sv
`timescale 1ns/100ps

module soc_periph_top (
   input  logic              bus,
   input  logic              rst_n,
   input  soc_pkg::bus_req_t bus_req,
   output logic [31:0]       rdat,
   output logic              rd_vld,
   input  logic [7:0]        gpio_in,
   output logic [7:0]        gpio_out,
   output logic              irq
);
   import soc_pkg::*;

   // Struct paths between registers and hardware
   csr_in_t     hw_in;
   csr_out_t    hw_out;

   // Timer half of hw_in
   logic [31:0] tmr_cnt;
   logic        tmr_match;
   // GPIO half of hw_in
   logic [7:0]  gpi_sync;
   logic        gpi_edge;

   // Both hardware halves joined into one struct
   assign hw_in = '{timer_cnt: tmr_cnt, timer_match: tmr_match,
                    gpio_in: gpi_sync, gpio_edge: gpi_edge};

   // CSR wrapper and register block
   soc_csr soc_csr_inst (
      .bus     (bus),
      .rst_n   (rst_n),
      .bus_req (bus_req),
      .rdat    (rdat),
      .rd_vld  (rd_vld),
      .hw_in   (hw_in),
      .hw_out  (hw_out),
      .irq     (irq)
   );

   // Compare timer
   soc_timer soc_timer_inst (
      .bus         (bus),
      .rst_n       (rst_n),
      .timer_en    (hw_out.timer_en),
      .prescale    (hw_out.prescale),
      .timer_cmp   (hw_out.timer_cmp),
      .timer_cnt   (tmr_cnt),
      .timer_match (tmr_match)
   );

   // GPIO port
   soc_gpio soc_gpio_inst (
      .bus      (bus),
      .rst_n    (rst_n),
      .out_val  (hw_out.gpio_out),
      .gpio_out (gpio_out),
      .gpio_in  (gpio_in),
      .in_sync  (gpi_sync),
      .in_edge  (gpi_edge)
   );

endmodule: soc_periph_top

//--- src/soc_gpio.sv
`timescale 1ns/100ps

module soc_gpio (
   input  logic       bus,
   input  logic       rst_n,
   input  logic [7:0] out_val,
   output logic [7:0] gpio_out,
   input  logic [7:0] gpio_in,
   output logic [7:0] in_sync,
   output logic       in_edge
);

   // First synchronizer stage, may go metastable
   logic [7:0] meta_q;
   // Last synchronized value, for edge detection
   logic [7:0] prev_q;

   // Output pins driven straight from a flop
   always_ff @(posedge bus) begin
      if (!rst_n) begin
         gpio_out <= '0;
      end else begin
         gpio_out <= out_val;
      end
   end

   // ==================================================
   // Input synchronizer and edge detect
   // ==================================================

   // Two stages, reset low so no edge appears after reset
   always_ff @(posedge bus) begin
      if (!rst_n) begin
         meta_q  <= '0;
         in_sync <= '0;
      end else begin
         meta_q  <= gpio_in;
         in_sync <= meta_q;
      end
   end

   // Pulse one cycle after any bit of in_sync rises
   always_ff @(posedge bus) begin
      if (!rst_n) begin
         prev_q  <= '0;
         in_edge <= 1'b0;
      end else begin
         prev_q  <= in_sync;
         in_edge <= |(in_sync & ~prev_q);
      end
   end

endmodule: soc_gpio

//--- src/soc_timer.sv
`timescale 1ns/100ps

module soc_timer (
   input  logic        bus,
   input  logic        rst_n,
   input  logic        timer_en,
   input  logic [7:0]  prescale,
   input  logic [31:0] timer_cmp,
   output logic [31:0] timer_cnt,
   output logic        timer_match
);

   // Prescale counter, one tick every prescale+1 cycles
   logic [7:0] psc_q;
   logic       tick;

   // Greater-or-equal so a smaller prescale written mid count still ticks
   assign tick = timer_en & (psc_q >= prescale);

   // Prescaler restarts on each tick and while disabled
   always_ff @(posedge bus) begin
      if (!rst_n) begin
         psc_q <= '0;
      end else if (!timer_en || tick) begin
         psc_q <= '0;
      end else begin
         psc_q <= psc_q + 8'd1;
      end
   end

   // ==================================================
   // Main counter and compare
   // ==================================================

   // Count holds while disabled, match is a single cycle pulse
   always_ff @(posedge bus) begin
      if (!rst_n) begin
         timer_cnt   <= '0;
         timer_match <= 1'b0;
      end else begin
         timer_match <= 1'b0;
         if (tick) begin
            // Also wraps if the compare value was lowered below the count
            if (timer_cnt >= timer_cmp) begin
               timer_cnt   <= '0;
               timer_match <= 1'b1;
            end else begin
               timer_cnt <= timer_cnt + 32'd1;
            end
         end
      end
   end

endmodule: soc_timer

//--- src/soc_csr.sv
`timescale 1ns/100ps

module soc_csr (
   input  logic              bus,
   input  logic              rst_n,
   input  soc_pkg::bus_req_t bus_req,
   output logic [31:0]       rdat,
   output logic              rd_vld,
   input  soc_pkg::csr_in_t  hw_in,
   output soc_pkg::csr_out_t hw_out,
   output logic              irq
);
   import soc_pkg::*;

   // Word index taken from the byte address
   logic [WORD_IDX_W-1:0] word_idx;
   // Byte strobes widened to one enable per bit
   logic [31:0]           wr_biten;
   // Any strobe set marks a write
   logic                  is_wr;

   // Drop the two byte offset bits
   assign word_idx = bus_req.addr[WORD_IDX_W+1:2];

   assign is_wr = |bus_req.we;

   // Each strobe covers one byte lane
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         wr_biten[8*i +: 8] = {8{bus_req.we[i]}};
      end
   end

   // No stall path, every valid request is taken at once
   csr_regs csr_regs_inst (
      .bus      (bus),
      .rst_n    (rst_n),

      .req      (bus_req.vld),
      .is_wr    (is_wr),
      .idx      (word_idx),
      .wr_data  (bus_req.wdat),
      .wr_biten (wr_biten),
      .rd_data  (rdat),
      .rd_ack   (rd_vld),

      .hw_in    (hw_in),
      .hw_out   (hw_out),
      .irq      (irq)
   );

endmodule: soc_csr

//--- src/csr_regs.sv
`timescale 1ns/100ps

module csr_regs (
   input  logic                           bus,
   input  logic                           rst_n,
   input  logic                           req,
   input  logic                           is_wr,
   input  logic [soc_pkg::WORD_IDX_W-1:0] idx,
   input  logic [31:0]                    wr_data,
   input  logic [31:0]                    wr_biten,
   output logic [31:0]                    rd_data,
   output logic                           rd_ack,
   input  soc_pkg::csr_in_t               hw_in,
   output soc_pkg::csr_out_t              hw_out,
   output logic                           irq
);
   import soc_pkg::*;

   // Writable registers
   logic [31:0] scratch_q;
   logic [31:0] ctrl_q;
   logic [31:0] cmp_q;
   logic [7:0]  gpo_q;
   // Sticky event bits
   logic [1:0]  status_q;

   // Decode
   logic        mapped;
   logic        wr_en;
   logic        rd_en;
   logic [1:0]  stat_set;
   logic [1:0]  stat_clr;
   logic [31:0] rd_mux;

   // Keep old bits where the enable is low
   function automatic logic [31:0] merge(input logic [31:0] old_val,
                                         input logic [31:0] new_val,
                                         input logic [31:0] biten);
      return (old_val & ~biten) | (new_val & biten);
   endfunction

   // ==================================================
   // Request decode
   // ==================================================

   // Only indices 0 to 7 hold registers
   assign mapped = (idx[WORD_IDX_W-1:3] == '0);
   assign wr_en  = req & is_wr & mapped;
   // Unmapped reads still get an ack with zero data
   assign rd_en  = req & ~is_wr;

   // ==================================================
   // Masked writes
   // ==================================================

   always_ff @(posedge bus) begin
      if (!rst_n) begin
         scratch_q <= '0;
         ctrl_q    <= '0;
         cmp_q     <= '0;
         gpo_q     <= '0;
      end else if (wr_en) begin
         case (idx[2:0])
            REG_SCRATCH:   scratch_q <= merge(scratch_q, wr_data, wr_biten);
            // Unused CTRL bits stay 0
            REG_CTRL:      ctrl_q    <= merge(ctrl_q, wr_data, wr_biten) & CTRL_MASK;
            REG_TIMER_CMP: cmp_q     <= merge(cmp_q, wr_data, wr_biten);
            REG_GPIO_OUT:  gpo_q     <= (gpo_q & ~wr_biten[7:0])
                                        | (wr_data[7:0] & wr_biten[7:0]);
            // ID, TIMER_CNT and GPIO_IN ignore writes
            // STATUS clears are handled in the sticky block
            default: ;
         endcase
      end
   end

   // ==================================================
   // Sticky status
   // ==================================================

   // Hardware events
   always_comb begin
      stat_set             = '0;
      stat_set[STAT_TIMER] = hw_in.timer_match;
      stat_set[STAT_GPIO]  = hw_in.gpio_edge;
   end

   // Write 1 clears each enabled bit
   assign stat_clr = (wr_en && idx[2:0] == REG_STATUS) ? (wr_data[1:0] & wr_biten[1:0])
                                                        : 2'b00;

   // Set applied after clear so a same cycle event survives
   always_ff @(posedge bus) begin
      if (!rst_n) begin
         status_q <= '0;
      end else begin
         status_q <= (status_q & ~stat_clr) | stat_set;
      end
   end

   // ==================================================
   // Read path
   // ==================================================

   always_comb begin
      rd_mux = '0;
      if (mapped) begin
         case (idx[2:0])
            REG_ID:        rd_mux = SOC_ID;
            REG_SCRATCH:   rd_mux = scratch_q;
            REG_CTRL:      rd_mux = ctrl_q;
            REG_TIMER_CMP: rd_mux = cmp_q;
            REG_TIMER_CNT: rd_mux = hw_in.timer_cnt;
            REG_STATUS:    rd_mux = {30'd0, status_q};
            REG_GPIO_OUT:  rd_mux = {24'd0, gpo_q};
            REG_GPIO_IN:   rd_mux = {24'd0, hw_in.gpio_in};
            default:       rd_mux = '0;
         endcase
      end
   end

   // Ack pulse one cycle after the request
   always_ff @(posedge bus) begin
      if (!rst_n) begin
         rd_ack <= 1'b0;
      end else begin
         rd_ack <= rd_en;
      end
   end

   // Read data captured with each read request
   always_ff @(posedge bus) begin
      if (rd_en) begin
         rd_data <= rd_mux;
      end
   end

   // ==================================================
   // Hardware outputs and interrupt
   // ==================================================

   assign hw_out.timer_en  = ctrl_q[CTRL_TIMER_EN];
   assign hw_out.prescale  = ctrl_q[CTRL_PRESC_LSB +: 8];
   assign hw_out.timer_cmp = cmp_q;
   assign hw_out.gpio_out  = gpo_q;

   // Enabled sticky bits summarized on one line
   always_ff @(posedge bus) begin
      if (!rst_n) begin
         irq <= 1'b0;
      end else begin
         irq <= (status_q[STAT_TIMER] & ctrl_q[CTRL_TIMER_IRQ_EN])
                | (status_q[STAT_GPIO] & ctrl_q[CTRL_GPIO_IRQ_EN]);
      end
   end

endmodule: csr_regs

//--- src/soc_pkg.sv
package soc_pkg;

   // ==================================================
   // Register map
   // ==================================================

   // Word index is byte address bits 6:2
   localparam int WORD_IDX_W = 5;

   // Word indices of the mapped registers
   localparam logic [2:0] REG_ID        = 3'd0;
   localparam logic [2:0] REG_SCRATCH   = 3'd1;
   localparam logic [2:0] REG_CTRL      = 3'd2;
   localparam logic [2:0] REG_TIMER_CMP = 3'd3;
   localparam logic [2:0] REG_TIMER_CNT = 3'd4;
   localparam logic [2:0] REG_STATUS    = 3'd5;
   localparam logic [2:0] REG_GPIO_OUT  = 3'd6;
   localparam logic [2:0] REG_GPIO_IN   = 3'd7;

   // Identification word returned by REG_ID
   localparam logic [31:0] SOC_ID = 32'h5043_0100;

   // CTRL bit positions
   localparam int CTRL_TIMER_EN     = 0;
   localparam int CTRL_TIMER_IRQ_EN = 1;
   localparam int CTRL_GPIO_IRQ_EN  = 2;
   // Prescale field sits in CTRL[15:8]
   localparam int CTRL_PRESC_LSB    = 8;
   // Bits that CTRL keeps, all others read back 0
   localparam logic [31:0] CTRL_MASK = 32'h0000_FF07;

   // STATUS bit positions, sticky, write 1 to clear
   localparam int STAT_TIMER = 0;
   localparam int STAT_GPIO  = 1;

   // ==================================================
   // Bus and hardware interface structs
   // ==================================================

   // One bus request, any strobe set means write
   typedef struct packed {
      logic        vld;
      logic [3:0]  we;
      logic [7:0]  addr;
      logic [31:0] wdat;
   } bus_req_t;

   // Register block to hardware
   typedef struct packed {
      logic        timer_en;
      logic [7:0]  prescale;
      logic [31:0] timer_cmp;
      logic [7:0]  gpio_out;
   } csr_out_t;

   // Hardware to register block
   typedef struct packed {
      logic [31:0] timer_cnt;
      logic        timer_match;   // one cycle pulse
      logic [7:0]  gpio_in;       // already synchronized
      logic        gpio_edge;     // one cycle pulse
   } csr_in_t;

endpackage: soc_pkg
